// ==== noc_pkg.sv ====
package noc_pkg;

	//////////////////////////////////////////////////
	// core word layout
	//////////////////////////////////////////////////

	localparam int route_w   = 10;                          // router address
	localparam int code_w    = 8;
	localparam int data_w    = 24;
	localparam int word_w    = route_w + code_w + data_w;   // 42
	localparam int payload_w = 30;                          // low bits that get routed

	//////////////////////////////////////////////////
	// flit layout
	//////////////////////////////////////////////////

	localparam int slice_w  = 10;         // payload bits per data flit
	localparam int flit_w   = 11;
	localparam int tail_bit = 10;         // msb, last flit of a packet

	// flit fifo sizing
	localparam int fifo_depth = 8;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam logic [fifo_ptr_w:0] fifo_full_count = fifo_depth[fifo_ptr_w:0];

	// serializer fsm encoding
	localparam int st_w = 3;
	localparam logic [st_w-1:0] st_idle   = 3'd0;
	localparam logic [st_w-1:0] st_header = 3'd1;
	localparam logic [st_w-1:0] st_slice1 = 3'd2; // payload 29:20
	localparam logic [st_w-1:0] st_slice2 = 3'd3; // payload 19:10
	localparam logic [st_w-1:0] st_slice3 = 3'd4; // payload 9:0, tail decided here

	// the same 42 bits, seen as fields or as route plus routed payload
	typedef union packed {
		struct packed {
			logic [route_w-1:0] route;
			logic [code_w-1:0]  code;
			logic [data_w-1:0]  data;
		} f;
		struct packed {
			logic [word_w-payload_w-1:0] unused;    // route and top code bits
			logic [payload_w-1:0]        payload;
		} r;
	} core_word_t;

endpackage

// ==== wb_core_port.sv ====
`timescale 1ns/1ps

module wb_core_port (
	input  logic                clk,
	input  logic                reset,

	// wishbone classic slave
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic                wb_adr,
	input  logic [31:0]         wb_dat_w,
	output logic                wb_ack,
	output logic [31:0]         wb_dat_r,

	// word channel to serializer
	output noc_pkg::core_word_t word,
	output logic                word_valid,
	input  logic                word_ack
);

	logic [noc_pkg::code_w+noc_pkg::data_w-1:0] low_q; // code + data, waits for commit
	logic req;
	logic is_commit;
	logic slot_free;
	logic ack_now;
	logic low_wr;
	logic commit;

	//////////////////////////////////////////////////
	// bus decode
	//////////////////////////////////////////////////

	assign req       = wb_cyc && wb_stb && !wb_ack;   // no second ack in the ack cycle
	assign is_commit = wb_we && wb_adr;               // high half write
	assign slot_free = !word_valid || word_ack;       // staged word leaving this cycle

	// commit waits on the staging slot, everything else acks next cycle
	assign ack_now = req && (!is_commit || slot_free);
	assign low_wr  = ack_now && wb_we && !wb_adr;
	assign commit  = ack_now && is_commit;

	// status word, bit 0 = word still staged
	assign wb_dat_r = {31'd0, word_valid};

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= ack_now; // single cycle pulse
		end
	end

	//////////////////////////////////////////////////
	// staging register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (low_wr)
			low_q <= wb_dat_w; // low half, all of code and data
	end

	// word only changes on commit, so it holds while valid
	always_ff @(posedge clk) begin
		if (commit) begin
			word.f.route <= wb_dat_w[noc_pkg::route_w-1:0];
			word.f.code  <= low_q[noc_pkg::code_w+noc_pkg::data_w-1:noc_pkg::data_w];
			word.f.data  <= low_q[noc_pkg::data_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			word_valid <= 1'b0;
		end else if (commit) begin
			word_valid <= 1'b1; // wins over a same cycle ack
		end else if (word_ack) begin
			word_valid <= 1'b0;
		end
	end

	// master holds cyc/stb until it sees ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack high outside a bus cycle");

endmodule

// ==== flit_serializer.sv ====
`timescale 1ns/1ps

module flit_serializer (
	input  logic                       clk,
	input  logic                       reset,

	// word channel from bus port
	input  noc_pkg::core_word_t        word,
	input  logic                       word_valid,
	output logic                       word_ack,

	// fifo write side
	output logic [noc_pkg::flit_w-1:0] fifo_data,
	output logic                       fifo_wr,
	input  logic                       fifo_full
);

	logic [noc_pkg::st_w-1:0]      state;
	logic [noc_pkg::st_w-1:0]      next_state;
	logic [noc_pkg::route_w-1:0]   header_q;   // route of the open packet
	logic [noc_pkg::payload_w-1:0] payload_q;  // word being sliced
	logic                          same_route;
	logic                          advance;
	logic                          load;

	// next word can ride in the open packet
	assign same_route = word_valid && (word.f.route == header_q);

	// one flit per cycle and stall in place on full
	assign advance = (state != noc_pkg::st_idle) && !fifo_full;
	assign fifo_wr = advance;

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			noc_pkg::st_idle:
				if (word_valid)
					next_state = noc_pkg::st_header;
			noc_pkg::st_header:
				if (advance)
					next_state = noc_pkg::st_slice1;
			noc_pkg::st_slice1:
				if (advance)
					next_state = noc_pkg::st_slice2;
			noc_pkg::st_slice2:
				if (advance)
					next_state = noc_pkg::st_slice3;
			noc_pkg::st_slice3:
				if (advance) begin
					if (same_route)
						next_state = noc_pkg::st_slice1;  // merge without a new header
					else if (word_valid)
						next_state = noc_pkg::st_header;  // new route opens a new packet
					else
						next_state = noc_pkg::st_idle;
				end
			default:
				next_state = noc_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= noc_pkg::st_idle;
		else
			state <= next_state;
	end

	// pick up a word from idle or straight after the last slice
	assign load = word_valid && ((state == noc_pkg::st_idle) ||
		(state == noc_pkg::st_slice3 && advance));

	always_ff @(posedge clk) begin
		if (load) begin
			header_q  <= word.f.route;
			payload_q <= word.r.payload;
		end
	end

	//////////////////////////////////////////////////
	// flit mux
	//////////////////////////////////////////////////

	always_comb begin
		fifo_data = '0;
		word_ack  = 1'b0;
		case (state)
			noc_pkg::st_header: begin
				fifo_data[noc_pkg::route_w-1:0] = header_q; // tail clear
			end
			noc_pkg::st_slice1: begin
				fifo_data[noc_pkg::slice_w-1:0] =
					payload_q[noc_pkg::payload_w-1 -: noc_pkg::slice_w];
				word_ack = advance; // word is latched so the slot can go
			end
			noc_pkg::st_slice2: begin
				fifo_data[noc_pkg::slice_w-1:0] =
					payload_q[noc_pkg::payload_w-noc_pkg::slice_w-1 -: noc_pkg::slice_w];
			end
			noc_pkg::st_slice3: begin
				fifo_data[noc_pkg::slice_w-1:0] = payload_q[noc_pkg::slice_w-1:0];
				fifo_data[noc_pkg::tail_bit]    = !same_route; // open packet stays open
			end
			default: begin
				fifo_data = '0;
			end
		endcase
	end

	// bus port must still be offering the word we consume
	a_ack_valid: assert property (@(posedge clk) disable iff (reset)
		word_ack |-> word_valid)
		else $error("word_ack without word_valid");

endmodule

// ==== flit_fifo.sv ====
`timescale 1ns/1ps

module flit_fifo (
	input  logic                       clk,
	input  logic                       reset,

	// write side, from serializer
	input  logic [noc_pkg::flit_w-1:0] fifo_data,
	input  logic                       fifo_wr,
	output logic                       fifo_full,

	// router side
	output logic [noc_pkg::flit_w-1:0] flit_data,
	output logic                       flit_valid,
	input  logic                       flit_ready
);

	logic [noc_pkg::flit_w-1:0]     mem [noc_pkg::fifo_depth];
	logic [noc_pkg::fifo_ptr_w-1:0] wr_ptr;
	logic [noc_pkg::fifo_ptr_w-1:0] rd_ptr;
	logic [noc_pkg::fifo_ptr_w:0]   count;    // one extra bit for full
	logic                           rd;

	//////////////////////////////////////////////////
	// flags and read port
	//////////////////////////////////////////////////

	assign fifo_full  = (count == noc_pkg::fifo_full_count);
	assign flit_valid = (count != '0);
	assign flit_data  = mem[rd_ptr];      // registered storage, no bypass
	assign rd         = flit_valid && flit_ready;

	//////////////////////////////////////////////////
	// storage and pointers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fifo_wr)
			mem[wr_ptr] <= fifo_data;
	end

	// depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (fifo_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({fifo_wr, rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // both or neither
			endcase
		end
	end

	// writer only sees full, overflow would drop a flit silently
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		fifo_full |-> !fifo_wr)
		else $error("flit fifo overflow");

endmodule

// ==== noc_injector_top.sv ====
`timescale 1ns/1ps

module noc_injector_top (
	input  logic                       clk,
	input  logic                       reset,

	// wishbone classic slave, from the core
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic                       wb_adr,
	input  logic [31:0]                wb_dat_w,
	output logic                       wb_ack,
	output logic [31:0]                wb_dat_r,

	// router input port
	output logic [noc_pkg::flit_w-1:0] flit_data,
	output logic                       flit_valid,
	input  logic                       flit_ready
);

	//////////////////////////////////////////////////
	// internal channels
	//////////////////////////////////////////////////

	noc_pkg::core_word_t        word;        // staged core word
	logic                       word_valid;
	logic                       word_ack;
	logic [noc_pkg::flit_w-1:0] fifo_data;
	logic                       fifo_wr;
	logic                       fifo_full;

	// decode: bus writes into words
	wb_core_port u_port (
		.clk        (clk),
		.reset      (reset),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_ack     (wb_ack),
		.wb_dat_r   (wb_dat_r),
		.word       (word),
		.word_valid (word_valid),
		.word_ack   (word_ack)
	);

	// execute: words into flits
	flit_serializer u_ser (
		.clk        (clk),
		.reset      (reset),
		.word       (word),
		.word_valid (word_valid),
		.word_ack   (word_ack),
		.fifo_data  (fifo_data),
		.fifo_wr    (fifo_wr),
		.fifo_full  (fifo_full)
	);

	// result: flit buffer toward the router
	flit_fifo u_fifo (
		.clk        (clk),
		.reset      (reset),
		.fifo_data  (fifo_data),
		.fifo_wr    (fifo_wr),
		.fifo_full  (fifo_full),
		.flit_data  (flit_data),
		.flit_valid (flit_valid),
		.flit_ready (flit_ready)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// power-on reset for three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;   // let go just after the edge
	end

endmodule

// ==== tb_packet_model.svh ====
`ifndef TB_PACKET_MODEL_SVH
`define TB_PACKET_MODEL_SVH

//////////////////////////////////////////////////
// packet model
//////////////////////////////////////////////////

// router view of one core word, {route, payload}
// the payload goes out as three slices, bits 29:20 first
function automatic logic [39:0] expected_pair(input logic [41:0] w);
	logic [9:0]  route;
	logic [29:0] payload;
	route   = w[41:32];   // top ten bits of the word
	payload = w[29:0];    // only the low 30 bits are routed
	return {route, payload};
endfunction

// every value check ends up here
task automatic check_equal(input string name, input logic [63:0] expected,
	input logic [63:0] actual);
	if (expected !== actual)
		stop_with_error($sformatf("Mismatch in %s: expected 'h%0h, actual 'h%0h",
			name, expected, actual));
endtask

`endif

// ==== tb_noc_injector.sv ====
`timescale 1ns/1ps

module tb_noc_injector;

	logic        clk;
	logic        por_reset;          // from clock generator
	logic        tb_reset;           // reset in the middle of traffic
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic        wb_adr;
	logic [31:0] wb_dat_w;
	logic        wb_ack;
	logic [31:0] wb_dat_r;
	logic [10:0] flit_data;
	logic        flit_valid;
	logic        flit_ready;

	// scoreboard and reassembler state
	logic [41:0] sent_q[$];          // words not yet rebuilt
	int          ready_mode = 1;     // 0 low, 1 high, 2 coin flip per cycle
	logic        in_packet = 1'b0;
	logic [9:0]  cur_route;
	logic [29:0] acc;                // slices of the current group
	int          slice_idx = 0;
	int          pkt_groups = 0;
	int          pkt_flits = 0;
	int          last_len = 0;       // flits of the last closed packet
	int          packets = 0;
	int          merged = 0;         // groups that rode under an open header
	int          commit_wait = 0;    // ack wait of the last committing write

	tb_clock_gen clkgen (.clk(clk), .reset(por_reset));
	assign reset = por_reset || tb_reset;

	noc_injector_top DUT (.*);

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	`include "tb_packet_model.svh"

	//////////////////////////////////////////////////
	// bus driver
	//////////////////////////////////////////////////

	task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] wdat,
		output logic [31:0] rdat, output int waited);
		@(posedge clk);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		waited   = 0;
		do begin
			@(negedge clk);   // registered ack is settled here
			waited++;
			if (waited > 200)
				stop_with_error("bus cycle timed out waiting for wb_ack");
		end while (!wb_ack);
		rdat = wb_dat_r;
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic send_word(input logic [41:0] w);
		logic [31:0] unused_rd;
		int          low_wait;
		sent_q.push_back(w);
		bus_cycle(1'b1, 1'b0, w[31:0], unused_rd, low_wait);                // code and data
		check_equal("low write ack wait", 64'd2, 64'(low_wait));
		bus_cycle(1'b1, 1'b1, {22'd0, w[41:32]}, unused_rd, commit_wait);   // route write commits
	endtask

	// route from a small set so neighbours often match
	function automatic logic [41:0] random_word();
		logic [41:0] w;
		w[31:0] = $urandom();
		case ($urandom() % 3)
			0:       w[41:32] = 10'h011;
			1:       w[41:32] = 10'h2a5;
			default: w[41:32] = 10'h3ff;
		endcase
		return w;
	endfunction

	task automatic set_ready(input int mode);
		@(negedge clk);
		ready_mode = mode;   // picked up at the next edge
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
			if (n > 3000)
				stop_with_error("output did not drain, flits lost or stuck");
		end while (sent_q.size() != 0 || flit_valid || in_packet);
	endtask

	//////////////////////////////////////////////////
	// router side
	//////////////////////////////////////////////////

	initial begin
		flit_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			case (ready_mode)
				0:       flit_ready = 1'b0;
				1:       flit_ready = 1'b1;
				default: flit_ready = 1'($urandom() % 2);
			endcase
		end
	end

	// rebuild packets flit by flit
	task automatic take_flit(input logic [10:0] f);
		logic [41:0] w;
		if (!in_packet) begin
			check_equal("header tail", 64'd0, 64'(f[noc_pkg::tail_bit]));
			cur_route  = f[9:0];
			in_packet  = 1'b1;
			slice_idx  = 0;
			pkt_groups = 0;
			pkt_flits  = 1;
		end else begin
			pkt_flits++;
			acc = {acc[19:0], f[9:0]};   // msb slice arrives first
			if (slice_idx < 2) begin
				check_equal("tail before third slice", 64'd0, 64'(f[noc_pkg::tail_bit]));
				slice_idx++;
			end else if (sent_q.size() == 0) begin
				stop_with_error("flit group arrived with no word left to match");
			end else begin
				w = sent_q.pop_front();
				check_equal("route and payload", 64'(expected_pair(w)), 64'({cur_route, acc}));
				if (pkt_groups > 0)
					merged++;
				pkt_groups++;
				slice_idx = 0;
				if (f[noc_pkg::tail_bit]) begin
					in_packet = 1'b0;
					last_len  = pkt_flits;
					packets++;
				end
			end
		end
	endtask

	// collector samples where valid and ready are settled
	initial begin
		forever begin
			@(negedge clk);
			if (reset) begin
				in_packet = 1'b0;   // partial packet dies with the reset
				sent_q.delete();
			end else if (flit_valid && flit_ready) begin
				take_flit(flit_data);
			end
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] status;
		int          n;
		int          merges_before;
		void'($urandom(32'hef10));
		tb_reset = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 1'b0;
		wb_dat_w = 32'd0;
		@(posedge clk);
		n = 0;
		while (reset) begin
			@(posedge clk);
			n++;
			if (n > 20)
				stop_with_error("power-on reset never released");
		end

		// single words give one packet of four flits each
		for (int i = 0; i < 4; i++) begin
			n = packets;
			send_word(random_word());
			wait_drained();
			check_equal("packets per single word", 64'(n + 1), 64'(packets));
			check_equal("flits per single word", 64'd4, 64'(last_len));
		end

		// random stream with a jittery router
		set_ready(2);
		for (int i = 0; i < 16; i++)
			send_word(random_word());
		set_ready(1);
		wait_drained();

		// stall the router until the fifo fills and the slot stays taken
		merges_before = merged;
		set_ready(0);
		send_word({10'h011, 32'h1234_5678});
		send_word({10'h2a5, 32'h9abc_def0});
		send_word({10'h3ff, 32'h0f0f_0f0f});
		bus_cycle(1'b0, 1'b1, 32'd0, status, n);
		check_equal("status while blocked", 64'd1, 64'(status));
		fork
			send_word({10'h3ff, 32'hcafe_f00d});   // same route as the staged word
			begin
				repeat (24) @(posedge clk);
				set_ready(1);
			end
		join
		check_equal("commit held back", 64'd1, 64'(commit_wait > 12));
		wait_drained();
		check_equal("merge seen", 64'd1, 64'(merged > merges_before));
		bus_cycle(1'b0, 1'b1, 32'd0, status, n);
		check_equal("status after drain", 64'd0, 64'(status));

		// reset with flits in flight
		send_word(random_word());
		send_word(random_word());
		set_ready(0);   // nothing transfers while reset is up
		@(posedge clk);
		#1;
		tb_reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		tb_reset = 1'b0;
		@(negedge clk);
		check_equal("flit_valid after reset", 64'd0, 64'(flit_valid));
		set_ready(1);
		send_word(random_word());
		wait_drained();

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
noc_pkg.sv
wb_core_port.sv
flit_serializer.sv
flit_fifo.sv
noc_injector_top.sv
tb_clock_gen.sv
tb_noc_injector.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the injector testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_noc_injector \
	-o tb_noc_injector_sim \
	&& ./obj_dir/tb_noc_injector_sim \
	|| exit 1
